//--- common/alu_isa_pkg.sv
package alu_isa_pkg;

	// Major opcode of register-register ALU instructions
	localparam logic [5:0] OP_R_ALU = 6'b101010;

	// Function field codes
	localparam logic [5:0] FN_VAND   = 6'b000001;
	localparam logic [5:0] FN_VOR    = 6'b000010;
	localparam logic [5:0] FN_VXOR   = 6'b000011;
	localparam logic [5:0] FN_VNOT   = 6'b000100;
	localparam logic [5:0] FN_VMOV   = 6'b000101;
	localparam logic [5:0] FN_VADD   = 6'b000110;
	localparam logic [5:0] FN_VSUB   = 6'b000111;
	localparam logic [5:0] FN_VMULEU = 6'b001000;
	localparam logic [5:0] FN_VMULOU = 6'b001001;
	localparam logic [5:0] FN_VRTTH  = 6'b001101;
	localparam logic [5:0] FN_VSQEU  = 6'b010000;
	localparam logic [5:0] FN_VSQOU  = 6'b010001;

	// Element width field
	localparam logic [1:0] W8  = 2'b00;
	localparam logic [1:0] W16 = 2'b01;
	localparam logic [1:0] W32 = 2'b10;
	localparam logic [1:0] W64 = 2'b11;

endpackage

//--- common/vec_types_pkg.sv
package vec_types_pkg;

	// Vector register width
	localparam int VEC_W = 64;

	// Lane counts per element width
	localparam int LANES_8  = VEC_W / 8;
	localparam int LANES_16 = VEC_W / 16;
	localparam int LANES_32 = VEC_W / 32;

	// One vector word, four lane views
	// Lane 0 sits in the most significant bits, as in the ISA bit order
	typedef union packed {
		logic [0:LANES_8-1][7:0]   b8;
		logic [0:LANES_16-1][15:0] h16;
		logic [0:LANES_32-1][31:0] w32;
		logic [VEC_W-1:0]          d64;
	} vec_word_u;

	// Instruction fields seen by the ALU
	typedef struct packed {
		logic [5:0] op_code;
		logic [5:0] func;
		logic [1:0] ww;
	} alu_cmd_t;

endpackage

//--- design/lane_addsub.sv
`timescale 1ns/1ps

// Lane-wise add or subtract, wrapping in every lane
module lane_addsub (
	input  vec_types_pkg::alu_cmd_t  cmd,
	input  vec_types_pkg::vec_word_u ra,
	input  vec_types_pkg::vec_word_u rb,
	output vec_types_pkg::vec_word_u sum
);

	logic is_sub;

	// Anything other than VSUB adds, result stage drops the rest
	assign is_sub = (cmd.func == alu_isa_pkg::FN_VSUB);

	// Each lane computed at its own width, so carries never cross
	always_comb begin
		sum = '0;
		case (cmd.ww)
			alu_isa_pkg::W8: begin
				for (int i = 0; i < vec_types_pkg::LANES_8; i++) begin
					sum.b8[i] = is_sub ? ra.b8[i] - rb.b8[i]
						: ra.b8[i] + rb.b8[i];
				end
			end
			alu_isa_pkg::W16: begin
				for (int i = 0; i < vec_types_pkg::LANES_16; i++) begin
					sum.h16[i] = is_sub ? ra.h16[i] - rb.h16[i]
						: ra.h16[i] + rb.h16[i];
				end
			end
			alu_isa_pkg::W32: begin
				for (int i = 0; i < vec_types_pkg::LANES_32; i++) begin
					sum.w32[i] = is_sub ? ra.w32[i] - rb.w32[i]
						: ra.w32[i] + rb.w32[i];
				end
			end
			alu_isa_pkg::W64: begin
				sum.d64 = is_sub ? ra.d64 - rb.d64 : ra.d64 + rb.d64;
			end
			default: begin
				sum = '0;
			end
		endcase
	end

endmodule

//--- design/lane_logic_unit.sv
`timescale 1ns/1ps

// Bitwise ops on the full word plus half-lane rotate
module lane_logic_unit (
	input  vec_types_pkg::alu_cmd_t  cmd,
	input  vec_types_pkg::vec_word_u ra,
	input  vec_types_pkg::vec_word_u rb,
	output vec_types_pkg::vec_word_u logic_out
);

	vec_types_pkg::vec_word_u rot;

	// Swap upper and lower half of every lane
	always_comb begin
		rot = '0;
		case (cmd.ww)
			alu_isa_pkg::W8: begin
				for (int i = 0; i < vec_types_pkg::LANES_8; i++) begin
					rot.b8[i] = {ra.b8[i][3:0], ra.b8[i][7:4]};
				end
			end
			alu_isa_pkg::W16: begin
				for (int i = 0; i < vec_types_pkg::LANES_16; i++) begin
					rot.h16[i] = {ra.h16[i][7:0], ra.h16[i][15:8]};
				end
			end
			alu_isa_pkg::W32: begin
				for (int i = 0; i < vec_types_pkg::LANES_32; i++) begin
					rot.w32[i] = {ra.w32[i][15:0], ra.w32[i][31:16]};
				end
			end
			default: begin
				rot.d64 = {ra.d64[31:0], ra.d64[63:32]};
			end
		endcase
	end

	always_comb begin
		case (cmd.func)
			alu_isa_pkg::FN_VAND:  logic_out = ra & rb;
			alu_isa_pkg::FN_VOR:   logic_out = ra | rb;
			alu_isa_pkg::FN_VXOR:  logic_out = ra ^ rb;
			alu_isa_pkg::FN_VNOT:  logic_out = ~ra;
			alu_isa_pkg::FN_VMOV:  logic_out = ra;
			alu_isa_pkg::FN_VRTTH: logic_out = rot;
			default:               logic_out = '0;
		endcase
	end

endmodule

//--- design/lane_multiplier.sv
`timescale 1ns/1ps

// Unsigned even/odd lane multiply, products land in double-width lanes
module lane_multiplier (
	input  vec_types_pkg::alu_cmd_t  cmd,
	input  vec_types_pkg::vec_word_u ra,
	input  vec_types_pkg::vec_word_u rb,
	output vec_types_pkg::vec_word_u product
);

	logic                     odd_sel;
	logic                     square;
	vec_types_pkg::vec_word_u fb;

	assign odd_sel = (cmd.func == alu_isa_pkg::FN_VMULOU) ||
		(cmd.func == alu_isa_pkg::FN_VSQOU);
	assign square = (cmd.func == alu_isa_pkg::FN_VSQEU) ||
		(cmd.func == alu_isa_pkg::FN_VSQOU);

	// Square reuses the multiplier with A on both inputs
	assign fb = square ? ra : rb;

	// Source lane 2k (even) or 2k+1 (odd) feeds product lane k
	always_comb begin
		product = '0;
		case (cmd.ww)
			alu_isa_pkg::W8: begin
				for (int k = 0; k < vec_types_pkg::LANES_16; k++) begin
					product.h16[k] = 16'(ra.b8[2*k + odd_sel]) *
						16'(fb.b8[2*k + odd_sel]);
				end
			end
			alu_isa_pkg::W16: begin
				for (int k = 0; k < vec_types_pkg::LANES_32; k++) begin
					product.w32[k] = 32'(ra.h16[2*k + odd_sel]) *
						32'(fb.h16[2*k + odd_sel]);
				end
			end
			alu_isa_pkg::W32: begin
				product.d64 = 64'(ra.w32[odd_sel]) * 64'(fb.w32[odd_sel]);
			end
			// No 128-bit lane to hold a 64x64 product
			default: begin
				product = '0;
			end
		endcase
	end

endmodule

//--- design/result_stage.sv
`timescale 1ns/1ps

// Result select and output register
module result_stage (
	input  logic                     clk,
	input  logic                     rst,
	input  vec_types_pkg::alu_cmd_t  cmd,
	input  vec_types_pkg::vec_word_u sum,
	input  vec_types_pkg::vec_word_u product,
	input  vec_types_pkg::vec_word_u logic_out,
	output vec_types_pkg::vec_word_u alu_out
);

	vec_types_pkg::vec_word_u result_next;

	// Only R-type produces a value, everything else reads as zero
	always_comb begin
		result_next = '0;
		if (cmd.op_code == alu_isa_pkg::OP_R_ALU) begin
			case (cmd.func)
				alu_isa_pkg::FN_VAND,
				alu_isa_pkg::FN_VOR,
				alu_isa_pkg::FN_VXOR,
				alu_isa_pkg::FN_VNOT,
				alu_isa_pkg::FN_VMOV,
				alu_isa_pkg::FN_VRTTH: begin
					result_next = logic_out;
				end
				alu_isa_pkg::FN_VADD,
				alu_isa_pkg::FN_VSUB: begin
					result_next = sum;
				end
				alu_isa_pkg::FN_VMULEU,
				alu_isa_pkg::FN_VMULOU,
				alu_isa_pkg::FN_VSQEU,
				alu_isa_pkg::FN_VSQOU: begin
					result_next = product;
				end
				default: begin
					result_next = '0;
				end
			endcase
		end
	end

	// One cycle from command to result
	always_ff @(posedge clk) begin
		if (rst) begin
			alu_out <= '0;
		end else begin
			alu_out <= result_next;
		end
	end

endmodule

//--- design/vec_alu.sv
`timescale 1ns/1ps

// SIMD vector ALU, one registered result per command
module vec_alu (
	input  logic                     clk,
	input  logic                     rst,
	input  vec_types_pkg::alu_cmd_t  cmd,
	input  vec_types_pkg::vec_word_u ra,
	input  vec_types_pkg::vec_word_u rb,
	output vec_types_pkg::vec_word_u alu_out
);

	vec_types_pkg::vec_word_u sum;
	vec_types_pkg::vec_word_u product;
	vec_types_pkg::vec_word_u logic_out;

	// Lane units, all combinational
	lane_addsub u_addsub (
		.cmd (cmd),
		.ra  (ra),
		.rb  (rb),
		.sum (sum)
	);

	lane_multiplier u_mult (
		.cmd     (cmd),
		.ra      (ra),
		.rb      (rb),
		.product (product)
	);

	lane_logic_unit u_logic (
		.cmd       (cmd),
		.ra        (ra),
		.rb        (rb),
		.logic_out (logic_out)
	);

	// Pick and register
	result_stage u_result (
		.clk       (clk),
		.rst       (rst),
		.cmd       (cmd),
		.sum       (sum),
		.product   (product),
		.logic_out (logic_out),
		.alu_out   (alu_out)
	);

endmodule

//--- project.f
common/vec_types_pkg.sv
common/alu_isa_pkg.sv
design/lane_addsub.sv
design/lane_multiplier.sv
design/lane_logic_unit.sv
design/result_stage.sv
design/vec_alu.sv
tb/vec_alu_properties.sv
tb/vec_alu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the vector ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module vec_alu_tb -f project.f -o vec_alu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/vec_alu_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tb/vec_alu_properties.sv
`timescale 1ns/1ps

// Concurrent checks on the registered ALU result
module vec_alu_properties (
	input logic                     clk,
	input logic                     rst,
	input vec_types_pkg::alu_cmd_t  cmd,
	input vec_types_pkg::vec_word_u ra,
	input vec_types_pkg::vec_word_u rb,
	input vec_types_pkg::vec_word_u alu_out
);

	int fail_count = 0;

	reset_clears: assert property (@(posedge clk) rst |=> alu_out.d64 == 64'd0)
	else begin
		fail_count = fail_count + 1;
		$error("alu_out not zero after a reset cycle");
	end

	// Only R-type commands produce a value
	non_r_zero: assert property (@(posedge clk)
		(!rst && cmd.op_code != alu_isa_pkg::OP_R_ALU) |=> alu_out.d64 == 64'd0)
	else begin
		fail_count = fail_count + 1;
		$error("non R-type opcode gave a nonzero result");
	end

	and_result: assert property (@(posedge clk)
		(!rst && cmd.op_code == alu_isa_pkg::OP_R_ALU && cmd.func == alu_isa_pkg::FN_VAND)
		|=> alu_out.d64 == ($past(ra.d64) & $past(rb.d64)))
	else begin
		fail_count = fail_count + 1;
		$error("AND result differs from operand AND");
	end

endmodule

bind vec_alu vec_alu_properties u_props (
	.clk     (clk),
	.rst     (rst),
	.cmd     (cmd),
	.ra      (ra),
	.rb      (rb),
	.alu_out (alu_out)
);

//--- tb/vec_alu_tb.sv
`timescale 1ns/1ps

module vec_alu_tb;

	localparam int W = vec_types_pkg::VEC_W;
	localparam int NUM_RANDOM = 2000;
	localparam int MAX_CYCLES = 5000;
	localparam logic [31:0] SEED = 32'hd463_96da;

	localparam logic [5:0] FN_LIST [12] = '{
		alu_isa_pkg::FN_VAND, alu_isa_pkg::FN_VOR, alu_isa_pkg::FN_VXOR,
		alu_isa_pkg::FN_VNOT, alu_isa_pkg::FN_VMOV, alu_isa_pkg::FN_VRTTH,
		alu_isa_pkg::FN_VADD, alu_isa_pkg::FN_VSUB, alu_isa_pkg::FN_VMULEU,
		alu_isa_pkg::FN_VMULOU, alu_isa_pkg::FN_VSQEU, alu_isa_pkg::FN_VSQOU
	};

	logic                     clk;
	logic                     rst;
	vec_types_pkg::alu_cmd_t  cmd;
	vec_types_pkg::vec_word_u ra;
	vec_types_pkg::vec_word_u rb;
	vec_types_pkg::vec_word_u alu_out;

	logic [31:0] rng_state;
	logic [63:0] expected;
	logic        pending;
	string       pending_name;

	vec_alu uut (
		.clk     (clk),
		.rst     (rst),
		.cmd     (cmd),
		.ra      (ra),
		.rb      (rb),
		.alu_out (alu_out)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [63:0] rand_word();
		logic [63:0] v;
		v[63:32] = next_rand();
		v[31:0] = next_rand();
		return v;
	endfunction

	function automatic logic [63:0] lane_mask(int lw);
		if (lw >= W) begin
			return '1;
		end
		return (64'd1 << lw) - 64'd1;
	endfunction

	// Lane 0 is the most significant lane
	function automatic logic [63:0] extract_lane(logic [63:0] w, int lw, int idx);
		return (w >> (W - (idx + 1) * lw)) & lane_mask(lw);
	endfunction

	function automatic logic [63:0] insert_lane(logic [63:0] w, int lw, int idx,
		logic [63:0] v);
		return w | ((v & lane_mask(lw)) << (W - (idx + 1) * lw));
	endfunction

	// Expected result built lane by lane from the ISA rules
	function automatic logic [63:0] model_result(vec_types_pkg::alu_cmd_t c,
		logic [63:0] a, logic [63:0] b);
		int lw;
		int lanes;
		int odd;
		logic [63:0] res;
		logic [63:0] x;
		logic [63:0] y;
		lw = 8 << c.ww;
		lanes = W / lw;
		res = '0;
		if (c.op_code != alu_isa_pkg::OP_R_ALU) begin
			return '0;
		end
		case (c.func)
			alu_isa_pkg::FN_VAND: res = a & b;
			alu_isa_pkg::FN_VOR:  res = a | b;
			alu_isa_pkg::FN_VXOR: res = a ^ b;
			alu_isa_pkg::FN_VNOT: res = ~a;
			alu_isa_pkg::FN_VMOV: res = a;
			alu_isa_pkg::FN_VRTTH: begin
				for (int i = 0; i < lanes; i++) begin
					x = extract_lane(a, lw, i);
					res = insert_lane(res, lw, i, (x << (lw / 2)) | (x >> (lw / 2)));
				end
			end
			alu_isa_pkg::FN_VADD, alu_isa_pkg::FN_VSUB: begin
				for (int i = 0; i < lanes; i++) begin
					x = extract_lane(a, lw, i);
					y = extract_lane(b, lw, i);
					res = insert_lane(res, lw, i,
						(c.func == alu_isa_pkg::FN_VSUB) ? x - y : x + y);
				end
			end
			alu_isa_pkg::FN_VMULEU, alu_isa_pkg::FN_VMULOU,
			alu_isa_pkg::FN_VSQEU, alu_isa_pkg::FN_VSQOU: begin
				odd = (c.func == alu_isa_pkg::FN_VMULOU || c.func == alu_isa_pkg::FN_VSQOU)
					? 1 : 0;
				if (lw < W) begin
					for (int k = 0; k < lanes / 2; k++) begin
						x = extract_lane(a, lw, 2 * k + odd);
						y = extract_lane(b, lw, 2 * k + odd);
						if (c.func == alu_isa_pkg::FN_VSQEU || c.func == alu_isa_pkg::FN_VSQOU) begin
							y = x;
						end
						res = insert_lane(res, 2 * lw, k, x * y);
					end
				end
			end
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic check_value(string name, logic [63:0] exp_val, logic [63:0] act_val);
		if (act_val !== exp_val) begin
			$display("mismatch %s expected %h actual %h", name, exp_val, act_val);
			$display("ERRORS FOUND");
			$fatal(1, "result check failed");
		end
	endtask

	// One command per cycle, the previous one is checked as the next goes in
	task automatic step(string name, vec_types_pkg::alu_cmd_t c, logic [63:0] a,
		logic [63:0] b);
		@(negedge clk);
		if (pending) begin
			check_value(pending_name, expected, alu_out.d64);
		end
		cmd = c;
		ra.d64 = a;
		rb.d64 = b;
		expected = model_result(c, a, b);
		pending_name = name;
		pending = 1'b1;
	endtask

	// Watchdog
	initial begin
		for (int i = 0; i < MAX_CYCLES; i++) begin
			@(posedge clk);
		end
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("ERRORS FOUND");
		$fatal(1, "timeout");
	end

	initial begin
		logic [31:0] r;
		logic [63:0] a;
		logic [63:0] b;
		vec_types_pkg::alu_cmd_t c;
		clk = 1'b0;
		rst = 1'b1;
		cmd = '0;
		ra = '0;
		rb = '0;
		rng_state = SEED;
		pending = 1'b0;
		expected = '0;
		pending_name = "";

		// Register stays clear under reset even with live R-type commands
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check_value("reset", 64'd0, alu_out.d64);
			cmd = '{alu_isa_pkg::OP_R_ALU, alu_isa_pkg::FN_VAND, 2'(i)};
			ra.d64 = rand_word();
			rb.d64 = rand_word();
		end
		rst = 1'b0;
		cmd = '0;

		for (int w = 0; w < 4; w++) begin
			for (int f = 0; f < 12; f++) begin
				c = '{alu_isa_pkg::OP_R_ALU, FN_LIST[f], 2'(w)};
				step("directed_random", c, rand_word(), rand_word());
				step("directed_max_a", c, '1, rand_word());
				step("directed_max_both", c, '1, '1);
			end
			// Lane overflow and underflow must not spill into the next lane
			step("add_wrap", '{alu_isa_pkg::OP_R_ALU, alu_isa_pkg::FN_VADD, 2'(w)},
				'1, 64'h0101_0101_0101_0101);
			step("sub_wrap", '{alu_isa_pkg::OP_R_ALU, alu_isa_pkg::FN_VSUB, 2'(w)},
				64'd0, 64'h0001_0001_0001_0001);
			step("bad_func", '{alu_isa_pkg::OP_R_ALU, 6'b001010, 2'(w)}, '1, '1);
			step("bad_func", '{alu_isa_pkg::OP_R_ALU, 6'b111111, 2'(w)}, '1, '1);
			step("non_r_opcode", '{6'b000000, alu_isa_pkg::FN_VMOV, 2'(w)}, '1, '1);
		end

		for (int n = 0; n < NUM_RANDOM; n++) begin
			r = next_rand();
			c.op_code = (r[3:0] == 4'd0) ? r[9:4] : alu_isa_pkg::OP_R_ALU;
			c.func = (r[12:10] == 3'd0) ? r[18:13] : FN_LIST[int'(next_rand() % 32'd12)];
			c.ww = r[20:19];
			a = (r[22:21] == 2'd0) ? '1 : rand_word();
			b = (r[24:23] == 2'd0) ? '1 : rand_word();
			step("random", c, a, b);
		end

		@(negedge clk);
		check_value(pending_name, expected, alu_out.d64);

		if (uut.u_props.fail_count != 0) begin
			$display("bound assertions failed %0d times", uut.u_props.fail_count);
			$display("ERRORS FOUND");
			$fatal(1, "assertion failures");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule
